//--- rtl/synth_params.svh
/*
 * Tone generator constants
 * Widths, voice count, phase step shift and sine table scale
 */
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

// ----------------------------------------------------------------------
// Voices and data path widths
// ----------------------------------------------------------------------
`define SYNTH_NUM_VOICES     4       // Live voice plus three captured
`define SYNTH_PHASE_W        32      // Phase accumulator
`define SYNTH_TUNE_W         18      // Switch word
`define SYNTH_TUNE_SHIFT     14      // Tune word lands in phase bits 31..14
`define SYNTH_INDEX_W        8       // Table address, top phase bits
`define SYNTH_SAMPLE_W       16      // Signed audio sample

// ----------------------------------------------------------------------
// Sine table
// ----------------------------------------------------------------------
`define SYNTH_QUARTER_OFFSET 64      // 90 degrees in table steps
`define SYNTH_SINE_PEAK      16383   // 2^14 - 1, leaves headroom for sums

`endif

//--- rtl/dds_pkg.sv
/*
 * DDS word types
 * Phase, tuning and sample words, plus the two views of a phase word
 */
package dds_pkg;

`include "synth_params.svh"

   // Raw accumulator word
   typedef logic [`SYNTH_PHASE_W-1:0] phase_t;

   // Switch word, also the stored tuning word
   typedef logic [`SYNTH_TUNE_W-1:0] tune_t;

   // One channel sample, two's complement
   typedef logic signed [`SYNTH_SAMPLE_W-1:0] sample_t;

   // Table view of a phase word
   typedef struct packed {
      logic [`SYNTH_INDEX_W-1:0]               index; // Table address
      logic [`SYNTH_PHASE_W-`SYNTH_INDEX_W-1:0] frac;  // Below table resolution
   } phase_fields_t;

   // Same 32 bits read two ways
   typedef union packed {
      phase_t        raw;   // Adder side
      phase_fields_t tbl;   // Lookup side
   } phase_u;

endpackage

//--- rtl/voice_pkg.sv
/*
 * Per-voice bundles
 * Words for all voices at once, as passed between pipeline stages
 */
package voice_pkg;

`include "synth_params.svh"

   // One tuning word per voice, slot 0 is the live switch word
   typedef dds_pkg::tune_t [`SYNTH_NUM_VOICES-1:0] voice_tunes_t;

   // One accumulator per voice
   typedef dds_pkg::phase_u [`SYNTH_NUM_VOICES-1:0] voice_phases_t;

   // Sine and cosine of one voice
   typedef struct packed {
      dds_pkg::sample_t sine;   // Right channel share
      dds_pkg::sample_t cosine; // Left channel share, quarter turn ahead
   } quad_sample_t;

   typedef quad_sample_t [`SYNTH_NUM_VOICES-1:0] voice_samples_t;

endpackage

//--- rtl/tune_memory.sv
/*
 * Tune memory
 * Voice 0 follows the switches live, voices 1 to 3 keep the first
 * switch word seen while their gate is held
 */
`timescale 1ns/1ps
`include "synth_params.svh"

module tune_memory (
   input  logic                  AUD_DACLRCK,
   input  logic                  rst,
   input  dds_pkg::tune_t        switch_word,
   input  logic [`SYNTH_NUM_VOICES-1:0] gate,
   output voice_pkg::voice_tunes_t tunes
);
   import dds_pkg::*;

   tune_t saved [1:`SYNTH_NUM_VOICES-1]; // Captured words, slot 0 not stored

   // ----------------------------------------------------------------------
   // Capture on first press, gate 0 wipes all
   // ----------------------------------------------------------------------
   always_ff @(posedge AUD_DACLRCK) begin
      if (rst) begin
         for (int k = 1; k < `SYNTH_NUM_VOICES; k++) saved[k] <= '0;
      end else begin
         for (int k = 1; k < `SYNTH_NUM_VOICES; k++) begin
            if (gate[0])
               saved[k] <= '0;                  // Clear wins over load
            else if (gate[k] && (saved[k] == '0))
               saved[k] <= switch_word;         // Empty slot only
         end
      end
   end

   // Live slot plus stored slots
   always_comb begin
      tunes[0] = switch_word;
      for (int k = 1; k < `SYNTH_NUM_VOICES; k++) tunes[k] = saved[k];
   end

endmodule

//--- rtl/phase_accumulator.sv
/*
 * Phase accumulators
 * One 32-bit accumulator per voice, stepping only while its gate is high
 */
`timescale 1ns/1ps
`include "synth_params.svh"

module phase_accumulator (
   input  logic                    AUD_DACLRCK,
   input  logic                    rst,
   input  voice_pkg::voice_tunes_t tunes,
   input  logic [`SYNTH_NUM_VOICES-1:0] gate,
   output voice_pkg::voice_phases_t phases
);
   import dds_pkg::*;

   phase_t step [`SYNTH_NUM_VOICES]; // Per-voice phase increment

   // ----------------------------------------------------------------------
   // Increment = tune word << 14
   // F = tune * fs / 2^18
   // ----------------------------------------------------------------------
   always_comb begin
      for (int k = 0; k < `SYNTH_NUM_VOICES; k++) begin
         step[k] = {tunes[k], {`SYNTH_TUNE_SHIFT{1'b0}}}; // 18 + 14 bits
      end
   end

   // Gated accumulate on the raw view
   always_ff @(posedge AUD_DACLRCK) begin
      if (rst) begin
         phases <= '0;
      end else begin
         for (int k = 0; k < `SYNTH_NUM_VOICES; k++) begin
            if (gate[k])
               phases[k].raw <= phases[k].raw + step[k]; // Wraps mod 2^32
         end
      end
   end

   // Released voice holds its phase
   // Table output stays at the last sample, no click on release

endmodule

//--- rtl/sine_lookup.sv
/*
 * Sine lookup
 * Quarter-wave table folded to a full cycle gives sine and cosine
 * per voice through one register stage
 */
`timescale 1ns/1ps
`include "synth_params.svh"

module sine_lookup (
   input  logic                      AUD_DACLRCK,
   input  logic                      rst,
   input  voice_pkg::voice_phases_t  phases,
   output voice_pkg::voice_samples_t samples
);
   import dds_pkg::*;

   // ----------------------------------------------------------------------
   // First quadrant 16383 * sin(2*pi*i/256) truncated for i = 0..64
   // ----------------------------------------------------------------------
   function automatic sample_t quarter_wave(input logic [`SYNTH_INDEX_W-2:0] pos);
      case (pos)
         7'd1:  quarter_wave = 16'sh0192;
         7'd2:  quarter_wave = 16'sh0323;
         7'd3:  quarter_wave = 16'sh04b5;
         7'd4:  quarter_wave = 16'sh0645;
         7'd5:  quarter_wave = 16'sh07d5;
         7'd6:  quarter_wave = 16'sh0963;
         7'd7:  quarter_wave = 16'sh0af0;
         7'd8:  quarter_wave = 16'sh0c7c;
         7'd9:  quarter_wave = 16'sh0e05;
         7'd10: quarter_wave = 16'sh0f8c;
         7'd11: quarter_wave = 16'sh1111;
         7'd12: quarter_wave = 16'sh1293;
         7'd13: quarter_wave = 16'sh1413;
         7'd14: quarter_wave = 16'sh158f;
         7'd15: quarter_wave = 16'sh1708;
         7'd16: quarter_wave = 16'sh187d; // 22.5 deg
         7'd17: quarter_wave = 16'sh19ef;
         7'd18: quarter_wave = 16'sh1b5c;
         7'd19: quarter_wave = 16'sh1cc5;
         7'd20: quarter_wave = 16'sh1e2a;
         7'd21: quarter_wave = 16'sh1f8b;
         7'd22: quarter_wave = 16'sh20e6;
         7'd23: quarter_wave = 16'sh223c;
         7'd24: quarter_wave = 16'sh238d;
         7'd25: quarter_wave = 16'sh24d9;
         7'd26: quarter_wave = 16'sh261f;
         7'd27: quarter_wave = 16'sh275f;
         7'd28: quarter_wave = 16'sh2899;
         7'd29: quarter_wave = 16'sh29cc;
         7'd30: quarter_wave = 16'sh2afa;
         7'd31: quarter_wave = 16'sh2c20;
         7'd32: quarter_wave = 16'sh2d40; // 45 deg
         7'd33: quarter_wave = 16'sh2e59;
         7'd34: quarter_wave = 16'sh2f6b;
         7'd35: quarter_wave = 16'sh3075;
         7'd36: quarter_wave = 16'sh3178;
         7'd37: quarter_wave = 16'sh3273;
         7'd38: quarter_wave = 16'sh3366;
         7'd39: quarter_wave = 16'sh3452;
         7'd40: quarter_wave = 16'sh3535;
         7'd41: quarter_wave = 16'sh3611;
         7'd42: quarter_wave = 16'sh36e4;
         7'd43: quarter_wave = 16'sh37ae;
         7'd44: quarter_wave = 16'sh3870;
         7'd45: quarter_wave = 16'sh3929;
         7'd46: quarter_wave = 16'sh39da;
         7'd47: quarter_wave = 16'sh3a81;
         7'd48: quarter_wave = 16'sh3b1f; // 67.5 deg
         7'd49: quarter_wave = 16'sh3bb5;
         7'd50: quarter_wave = 16'sh3c41;
         7'd51: quarter_wave = 16'sh3cc4;
         7'd52: quarter_wave = 16'sh3d3d;
         7'd53: quarter_wave = 16'sh3dad;
         7'd54: quarter_wave = 16'sh3e14;
         7'd55: quarter_wave = 16'sh3e70;
         7'd56: quarter_wave = 16'sh3ec4;
         7'd57: quarter_wave = 16'sh3f0d;
         7'd58: quarter_wave = 16'sh3f4d;
         7'd59: quarter_wave = 16'sh3f83;
         7'd60: quarter_wave = 16'sh3fb0;
         7'd61: quarter_wave = 16'sh3fd2;
         7'd62: quarter_wave = 16'sh3feb;
         7'd63: quarter_wave = 16'sh3ffa;
         7'd64: quarter_wave = sample_t'(`SYNTH_SINE_PEAK); // 90 deg
         default: quarter_wave = '0;              // Index 0 only, 65 and up never addressed
      endcase
   endfunction

   // ----------------------------------------------------------------------
   // Fold by quadrant
   // Odd quadrant mirrors the offset and upper half negates
   // ----------------------------------------------------------------------
   function automatic sample_t sine_at(input logic [`SYNTH_INDEX_W-1:0] index);
      logic [`SYNTH_INDEX_W-2:0] pos;
      sample_t                   mag;
      pos = {1'b0, index[`SYNTH_INDEX_W-3:0]};     // Offset in quadrant
      if (index[`SYNTH_INDEX_W-2])
         pos = (`SYNTH_INDEX_W-1)'(`SYNTH_QUARTER_OFFSET) - pos; // Falling edge
      mag = quarter_wave(pos);
      sine_at = index[`SYNTH_INDEX_W-1] ? -mag : mag; // Truncation is symmetric
   endfunction

   // Cosine index wraps mod 256 in 8 bits
   always_ff @(posedge AUD_DACLRCK) begin
      if (rst) begin
         samples <= '0;
      end else begin
         for (int k = 0; k < `SYNTH_NUM_VOICES; k++) begin
            samples[k].sine   <= sine_at(phases[k].tbl.index);
            samples[k].cosine <= sine_at(phases[k].tbl.index
                                         + (`SYNTH_INDEX_W)'(`SYNTH_QUARTER_OFFSET));
         end
      end
   end

endmodule

//--- rtl/voice_mixer.sv
/*
 * Voice mixer
 * Registered sums of all voices, sines to the right channel and
 * cosines to the left, wrapping at 16 bits
 */
`timescale 1ns/1ps
`include "synth_params.svh"

module voice_mixer (
   input  logic                      AUD_DACLRCK,
   input  logic                      rst,
   input  voice_pkg::voice_samples_t samples,
   output dds_pkg::sample_t          audio_left,
   output dds_pkg::sample_t          audio_right
);
   import dds_pkg::*;

   sample_t sum_sine;   // Right channel, before the register
   sample_t sum_cosine; // Left channel, before the register

   // No saturation, four full-scale voices wrap
   always_comb begin
      sum_sine   = '0;
      sum_cosine = '0;
      for (int k = 0; k < `SYNTH_NUM_VOICES; k++) begin
         sum_sine   = sum_sine + samples[k].sine;     // Mod 2^16
         sum_cosine = sum_cosine + samples[k].cosine;
      end
   end

   // Output stage
   always_ff @(posedge AUD_DACLRCK) begin
      if (rst) begin
         audio_left  <= '0;
         audio_right <= '0;
      end else begin
         audio_left  <= sum_cosine;
         audio_right <= sum_sine;
      end
   end

endmodule

//--- rtl/synth_top.sv
/*
 * Four-voice DDS tone generator
 * Tune memory, phase accumulators, sine lookup and mixer in a chain
 */
`timescale 1ns/1ps
`include "synth_params.svh"

module synth_top (
   input  logic                         AUD_DACLRCK, // Sample clock
   input  logic                         rst,
   input  dds_pkg::tune_t               switch_word,
   input  logic [`SYNTH_NUM_VOICES-1:0] gate,        // Active high, one per voice
   output dds_pkg::sample_t             audio_left,
   output dds_pkg::sample_t             audio_right
);
   import voice_pkg::*;

   voice_tunes_t   tunes;   // Live slot 0, stored 1..3
   voice_phases_t  phases;  // Registered
   voice_samples_t samples; // Registered, one cycle after phases

   // ----------------------------------------------------------------------
   // Pipeline, phase update to output is two edges
   // ----------------------------------------------------------------------
   tune_memory tune_memory_inst (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .switch_word (switch_word),
      .gate        (gate),
      .tunes       (tunes)
   );

   phase_accumulator phase_accumulator_inst (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .tunes       (tunes),
      .gate        (gate),
      .phases      (phases)
   );

   sine_lookup sine_lookup_inst (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .phases      (phases),
      .samples     (samples)
   );

   voice_mixer voice_mixer_inst (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .samples     (samples),
      .audio_left  (audio_left),
      .audio_right (audio_right)
   );

endmodule

//--- testbench/synth_tb.sv
/*
 * Testbench for the four-voice DDS tone generator
 * Directed tests checked every cycle against a reference model
 */
`timescale 1ns/1ps

module synth_tb;

   localparam int  CLK_PERIOD     = 10;
   localparam int  RESET_CYCLES   = 10;
   localparam int  IDLE_CYCLES    = 8;
   localparam int  LIVE_CYCLES    = 300;
   localparam int  CAPTURE_CYCLES = 200;
   localparam int  CHORD_CYCLES   = 300;
   localparam int  RECAP_CYCLES   = 200;
   localparam int  SETUP_CYCLES   = 20;   // Gate pulses and gaps per test
   localparam int  TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + LIVE_CYCLES
                                  + CAPTURE_CYCLES + CHORD_CYCLES + RECAP_CYCLES
                                  + 5 * SETUP_CYCLES + 100;
   localparam real PI             = 3.14159265358979;

   logic        AUD_DACLRCK;
   logic        rst;
   logic [17:0] switch_word;
   logic [3:0]  gate;
   logic [15:0] audio_left;
   logic [15:0] audio_right;

   int errors = 0;
   int sine_table [256];    // Full-cycle reference table

   // Reference model state
   logic [17:0] m_saved [1:3];
   logic [31:0] m_phase [4];
   logic [15:0] m_left_d1;  // After the lookup stage
   logic [15:0] m_right_d1;
   logic [15:0] m_left;     // After the mixer stage
   logic [15:0] m_right;

   synth_top synth_top_inst (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .switch_word (switch_word),
      .gate        (gate),
      .audio_left  (audio_left),
      .audio_right (audio_right)
   );

   initial begin
      AUD_DACLRCK = 1'b0;
      forever #(CLK_PERIOD / 2) AUD_DACLRCK = ~AUD_DACLRCK;
   end

   // 16383 * sin truncated toward zero
   initial begin
      for (int i = 0; i < 256; i++)
         sine_table[i] = $rtoi(16383.0 * $sin(2.0 * PI * i / 256.0));
   end

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------
   function automatic logic [17:0] model_tune(input int k);
      if (k == 0)
         return switch_word;  // Live voice
      else
         return m_saved[k];
   endfunction

   // Wrapped sum of all voices where offset 64 gives the cosine
   function automatic logic [15:0] model_sum(input int offset);
      int         acc;
      logic [7:0] idx;
      acc = 0;
      for (int k = 0; k < 4; k++) begin
         idx = m_phase[k][31:24] + 8'(offset);  // Mod 256
         acc = acc + sine_table[idx];
      end
      return acc[15:0];
   endfunction

   always @(posedge AUD_DACLRCK) begin
      if (rst) begin
         for (int k = 1; k < 4; k++)
            m_saved[k] <= '0;
         for (int k = 0; k < 4; k++)
            m_phase[k] <= '0;
         m_left_d1  <= '0;
         m_right_d1 <= '0;
         m_left     <= '0;
         m_right    <= '0;
      end else begin
         for (int k = 1; k < 4; k++) begin
            if (gate[0])
               m_saved[k] <= '0;             // Clear first
            else if (gate[k] && m_saved[k] == '0)
               m_saved[k] <= switch_word;
         end
         for (int k = 0; k < 4; k++) begin
            if (gate[k])
               m_phase[k] <= m_phase[k] + {model_tune(k), 14'b0};
         end
         m_right_d1 <= model_sum(0);
         m_left_d1  <= model_sum(64);
         m_right    <= m_right_d1;               // Second delay stage
         m_left     <= m_left_d1;
      end
   end

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
      if (got !== expected) begin
         errors++;
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
      end
   endtask

   task automatic drive(input logic [17:0] word, input logic [3:0] gates);
      @(posedge AUD_DACLRCK);
      switch_word <= word;
      gate        <= gates;
   endtask

   // Compare both channels with the model at each falling edge
   task automatic run_cycles(input int n);
      repeat (n) begin
         @(negedge AUD_DACLRCK);
         check_value("audio_left", audio_left, m_left);
         check_value("audio_right", audio_right, m_right);
      end
   endtask

   function automatic logic [17:0] random_tune();
      logic [17:0] w;
      w = '0;
      while (w == '0)
         w = 18'($urandom);   // Zero would never stick in a slot
      return w;
   endfunction

   // ----------------------------------------------------------------------
   // Tests
   // ----------------------------------------------------------------------
   task automatic test_idle_after_reset();
      repeat (2) begin
         @(negedge AUD_DACLRCK);
         check_value("audio_left", audio_left, 16'h0000);
         check_value("audio_right", audio_right, 16'h0000);
      end
      repeat (IDLE_CYCLES) begin
         @(negedge AUD_DACLRCK);
         check_value("audio_left", audio_left, 16'hfffc);  // Four voices at cos(0) wrap
         check_value("audio_right", audio_right, 16'h0000);
      end
   endtask

   task automatic test_live_voice();
      drive(random_tune(), 4'b0001);
      run_cycles(LIVE_CYCLES);    // Both channels every cycle
      drive(switch_word, 4'b0000);
      run_cycles(4);
   endtask

   task automatic test_capture_first_press();
      logic [17:0] first_word;
      logic [17:0] second_word;
      first_word  = random_tune();
      second_word = random_tune();
      while (second_word == first_word)
         second_word = random_tune();
      drive(first_word, 4'b0010);
      run_cycles(1);
      drive(first_word, 4'b0000);
      run_cycles(4);
      drive(second_word, 4'b0010);  // Slot full so the first word stays
      run_cycles(CAPTURE_CYCLES);
      drive(second_word, 4'b0000);
      run_cycles(4);
   endtask

   task automatic test_chord();
      drive(random_tune(), 4'b0001);  // Empty all slots
      run_cycles(2);
      for (int k = 1; k < 4; k++) begin
         drive(random_tune(), 4'b0001 << k);
         run_cycles(1);
      end
      drive(random_tune(), 4'b1110);  // Three voices whose sums may wrap
      run_cycles(CHORD_CYCLES);
      drive(switch_word, 4'b0000);
      run_cycles(4);
   endtask

   task automatic test_clear_and_recapture();
      logic [17:0] blocked_word;
      logic [17:0] new_word;
      drive(switch_word, 4'b0001);    // Wipes the chord words
      run_cycles(2);
      blocked_word = random_tune();
      drive(blocked_word, 4'b0101);   // Clear beats the load into empty slot 2
      run_cycles(1);
      drive(blocked_word, 4'b0000);
      run_cycles(2);
      new_word = random_tune();
      while (new_word == blocked_word)
         new_word = random_tune();
      drive(new_word, 4'b0100);
      run_cycles(RECAP_CYCLES);
      drive(new_word, 4'b0000);
      run_cycles(4);
   endtask

   // ----------------------------------------------------------------------
   // Sequence and watchdog
   // ----------------------------------------------------------------------
   initial begin
      void'($urandom(92933));
      rst         = 1'b1;
      switch_word = '0;
      gate        = '0;
      repeat (RESET_CYCLES) @(posedge AUD_DACLRCK);
      rst <= 1'b0;
      test_idle_after_reset();
      test_live_voice();
      test_capture_first_press();
      test_chord();
      test_clear_and_recapture();
      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

//--- synth.f
+incdir+rtl
rtl/dds_pkg.sv
rtl/voice_pkg.sv
rtl/tune_memory.sv
rtl/phase_accumulator.sv
rtl/sine_lookup.sv
rtl/voice_mixer.sv
rtl/synth_top.sv
testbench/synth_tb.sv

//--- Bender.yml
package:
  name: synth

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dds_pkg.sv
      - rtl/voice_pkg.sv
      - rtl/tune_memory.sv
      - rtl/phase_accumulator.sv
      - rtl/sine_lookup.sv
      - rtl/voice_mixer.sv
      - rtl/synth_top.sv
  - target: test
    files:
      - testbench/synth_tb.sv
